// ==== src/apb_pkg.sv ====
package apb_pkg;

    // bus widths of every APB port in the subsystem.
    localparam int addr_width = 32;
    localparam int data_width = 32;
    localparam int strb_width = data_width / 8;
    localparam int prot_width = 3;

    // address bit 12 picks the region, 0 for the config block and 1 for the memory.
    localparam int region_bit = 12;

    // any bit set above the region bit means the address is unmapped.
    localparam logic [addr_width-1:0] region_high_mask = 32'hffff_e000;

    // word memory behind the delayer.
    localparam int mem_words = 256;
    localparam int mem_wait_cycles = 3;

endpackage

// ==== src/delay_pkg.sv ====
package delay_pkg;

    // the ratio is unsigned fixed point with this many fraction bits.
    localparam int ratio_frac_bits = 10;
    localparam int counter_width = 48;

    localparam int state_width = 2;
    localparam logic [state_width-1:0] state_idle = 2'd0;
    localparam logic [state_width-1:0] state_active = 2'd1;
    localparam logic [state_width-1:0] state_delay = 2'd2;

    // register offsets inside the config region.
    localparam int reg_offset_width = 12;
    localparam logic [reg_offset_width-1:0] reg_ctrl_offset = 12'h000;
    localparam logic [reg_offset_width-1:0] reg_ratio_offset = 12'h004;
    localparam logic [reg_offset_width-1:0] reg_count_offset = 12'h008;

    // 1.0 with ten fraction bits.
    localparam logic [31:0] ratio_reset = 32'h0000_0400;

endpackage

// ==== src/apb_region_decoder.sv ====
`timescale 1ns/1ps

module apb_region_decoder (
    input  logic [apb_pkg::addr_width-1:0] up_paddr,
    input  logic                           up_psel,
    input  logic                           up_penable,
    input  logic [apb_pkg::prot_width-1:0] up_pprot,
    input  logic                           up_pwrite,
    input  logic [apb_pkg::data_width-1:0] up_pwdata,
    input  logic [apb_pkg::strb_width-1:0] up_pstrb,
    output logic                           up_pready,
    output logic [apb_pkg::data_width-1:0] up_prdata,
    output logic                           up_pslverr,

    output logic                           cfg_psel,
    output logic                           cfg_penable,
    output logic [apb_pkg::addr_width-1:0] cfg_paddr,
    output logic                           cfg_pwrite,
    output logic [apb_pkg::data_width-1:0] cfg_pwdata,
    output logic [apb_pkg::strb_width-1:0] cfg_pstrb,
    input  logic                           cfg_pready,
    input  logic [apb_pkg::data_width-1:0] cfg_prdata,
    input  logic                           cfg_pslverr,

    output logic                           dly_psel,
    output logic                           dly_penable,
    output logic [apb_pkg::addr_width-1:0] dly_paddr,
    output logic [apb_pkg::prot_width-1:0] dly_pprot,
    output logic                           dly_pwrite,
    output logic [apb_pkg::data_width-1:0] dly_pwdata,
    output logic [apb_pkg::strb_width-1:0] dly_pstrb,
    input  logic                           dly_pready,
    input  logic [apb_pkg::data_width-1:0] dly_prdata,
    input  logic                           dly_pslverr
);

    logic unmapped;
    logic mem_region;

    assign unmapped = |(up_paddr & apb_pkg::region_high_mask);
    assign mem_region = up_paddr[apb_pkg::region_bit];

    assign cfg_psel = up_psel && !unmapped && !mem_region;
    assign cfg_penable = up_penable && cfg_psel;
    assign cfg_paddr = up_paddr;
    assign cfg_pwrite = up_pwrite;
    assign cfg_pwdata = up_pwdata;
    assign cfg_pstrb = up_pstrb;

    assign dly_psel = up_psel && !unmapped && mem_region;
    assign dly_penable = up_penable && dly_psel;
    assign dly_paddr = up_paddr;
    assign dly_pprot = up_pprot;
    assign dly_pwrite = up_pwrite;
    assign dly_pwdata = up_pwdata;
    assign dly_pstrb = up_pstrb;

    // unmapped accesses are answered here in the first access cycle.
    always_comb begin
        if (unmapped) begin
            up_pready = up_psel && up_penable;
            up_prdata = '0;
            up_pslverr = up_psel && up_penable;
        end else if (mem_region) begin
            up_pready = dly_pready;
            up_prdata = dly_prdata;
            up_pslverr = dly_pslverr;
        end else begin
            up_pready = cfg_pready;
            up_prdata = cfg_prdata;
            up_pslverr = cfg_pslverr;
        end
    end

endmodule

// ==== src/delay_config_regs.sv ====
`timescale 1ns/1ps

module delay_config_regs (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           psel,
    input  logic                           penable,
    input  logic [apb_pkg::addr_width-1:0] paddr,
    input  logic                           pwrite,
    input  logic [apb_pkg::data_width-1:0] pwdata,
    input  logic [apb_pkg::strb_width-1:0] pstrb,
    input  logic                           access_done,
    output logic                           pready,
    output logic [apb_pkg::data_width-1:0] prdata,
    output logic                           pslverr,
    output logic                           delay_enable,
    output logic [apb_pkg::data_width-1:0] delay_ratio
);

    logic [delay_pkg::reg_offset_width-1:0] offset;
    logic [apb_pkg::data_width-1:0]         read_data;
    logic [apb_pkg::data_width-1:0]         done_count;
    logic                                   bad_access;

    assign offset = paddr[delay_pkg::reg_offset_width-1:0];
    assign pready = psel && penable;
    assign pslverr = pready && bad_access;
    assign prdata = (pready && !pwrite && !bad_access) ? read_data : '0;

    always_comb begin
        read_data = '0;
        bad_access = 1'b0;
        case (offset)
            delay_pkg::reg_ctrl_offset: read_data[0] = delay_enable;
            delay_pkg::reg_ratio_offset: read_data = delay_ratio;
            delay_pkg::reg_count_offset: begin
                read_data = done_count;
                // the count is read only.
                bad_access = pwrite;
            end
            default: bad_access = 1'b1;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            delay_enable <= 1'b0;
            delay_ratio <= delay_pkg::ratio_reset;
            done_count <= '0;
        end else begin
            if (access_done) begin
                done_count <= done_count + 1'b1;
            end
            if (pready && pwrite && !bad_access) begin
                if (offset == delay_pkg::reg_ctrl_offset && pstrb[0]) begin
                    delay_enable <= pwdata[0];
                end
                if (offset == delay_pkg::reg_ratio_offset) begin
                    for (int b = 0; b < apb_pkg::strb_width; b++) begin
                        if (pstrb[b]) begin
                            delay_ratio[b*8 +: 8] <= pwdata[b*8 +: 8];
                        end
                    end
                end
            end
        end
    end

endmodule

// ==== src/apb_delayer.sv ====
`timescale 1ns/1ps

module apb_delayer (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           delay_enable,
    input  logic [apb_pkg::data_width-1:0] delay_ratio,

    input  logic [apb_pkg::addr_width-1:0] in_paddr,
    input  logic                           in_psel,
    input  logic                           in_penable,
    input  logic [apb_pkg::prot_width-1:0] in_pprot,
    input  logic                           in_pwrite,
    input  logic [apb_pkg::data_width-1:0] in_pwdata,
    input  logic [apb_pkg::strb_width-1:0] in_pstrb,
    output logic                           in_pready,
    output logic [apb_pkg::data_width-1:0] in_prdata,
    output logic                           in_pslverr,

    output logic [apb_pkg::addr_width-1:0] out_paddr,
    output logic                           out_psel,
    output logic                           out_penable,
    output logic [apb_pkg::prot_width-1:0] out_pprot,
    output logic                           out_pwrite,
    output logic [apb_pkg::data_width-1:0] out_pwdata,
    output logic [apb_pkg::strb_width-1:0] out_pstrb,
    input  logic                           out_pready,
    input  logic [apb_pkg::data_width-1:0] out_prdata,
    input  logic                           out_pslverr,

    output logic                           access_done
);

    logic [delay_pkg::state_width-1:0]   state;
    logic [delay_pkg::counter_width-1:0] delay_count;
    logic [apb_pkg::data_width-1:0]      held_prdata;
    logic                                held_pslverr;
    logic                                held_ready;
    logic                                setup;

    // the request always goes straight through to the memory.
    assign out_paddr = in_paddr;
    assign out_psel = in_psel;
    assign out_penable = in_penable;
    assign out_pprot = in_pprot;
    assign out_pwrite = in_pwrite;
    assign out_pwdata = in_pwdata;
    assign out_pstrb = in_pstrb;

    assign setup = delay_enable && in_psel && !in_penable;

    assign in_pready = delay_enable ? held_ready : out_pready;
    assign in_prdata = delay_enable ? (held_ready ? held_prdata : '0) : out_prdata;
    assign in_pslverr = delay_enable ? (held_ready && held_pslverr) : out_pslverr;
    assign access_done = held_ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= delay_pkg::state_idle;
            delay_count <= '0;
            held_ready <= 1'b0;
        end else begin
            held_ready <= 1'b0;
            case (state)
                delay_pkg::state_idle: begin
                    if (setup) begin
                        state <= delay_pkg::state_active;
                        delay_count <= '0;
                    end
                end
                delay_pkg::state_active: begin
                    // each memory wait cycle adds the ratio, the integer part is kept.
                    if (out_pready) begin
                        delay_count <= delay_count >> delay_pkg::ratio_frac_bits;
                        state <= delay_pkg::state_delay;
                    end else begin
                        delay_count <= delay_count + delay_pkg::counter_width'(delay_ratio);
                    end
                end
                delay_pkg::state_delay: begin
                    if (delay_count == '0) begin
                        held_ready <= 1'b1;
                        state <= delay_pkg::state_idle;
                    end else begin
                        delay_count <= delay_count - 1'b1;
                    end
                end
                default: state <= delay_pkg::state_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == delay_pkg::state_active && out_pready) begin
            held_prdata <= out_prdata;
            held_pslverr <= out_pslverr;
        end
    end

endmodule

// ==== src/apb_wait_memory.sv ====
`timescale 1ns/1ps

module apb_wait_memory (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           psel,
    input  logic                           penable,
    input  logic [apb_pkg::addr_width-1:0] paddr,
    input  logic                           pwrite,
    input  logic [apb_pkg::data_width-1:0] pwdata,
    input  logic [apb_pkg::strb_width-1:0] pstrb,
    output logic                           pready,
    output logic [apb_pkg::data_width-1:0] prdata,
    output logic                           pslverr
);

    localparam int index_lsb = $clog2(apb_pkg::strb_width);
    localparam int index_width = apb_pkg::region_bit - index_lsb;
    localparam int array_width = $clog2(apb_pkg::mem_words);
    localparam int wait_width = $clog2(apb_pkg::mem_wait_cycles + 2);

    logic [apb_pkg::data_width-1:0] mem [apb_pkg::mem_words];
    logic [wait_width-1:0]          wait_count;
    logic [index_width-1:0]         word_index;
    logic [array_width-1:0]         array_index;
    logic                           access;
    logic                           in_range;

    assign access = psel && penable;
    assign word_index = paddr[apb_pkg::region_bit-1:index_lsb];
    assign array_index = word_index[array_width-1:0];
    assign in_range = int'(word_index) < apb_pkg::mem_words;

    assign pready = access && (wait_count == wait_width'(apb_pkg::mem_wait_cycles));
    assign pslverr = pready && !in_range;
    assign prdata = (pready && in_range && !pwrite) ? mem[array_index] : '0;

    // counts low access cycles, so a held request sees the ready cycle again.
    always_ff @(posedge clock) begin
        if (reset) begin
            wait_count <= '0;
        end else if (!access || pready) begin
            wait_count <= '0;
        end else begin
            wait_count <= wait_count + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (pready && pwrite && in_range) begin
            for (int b = 0; b < apb_pkg::strb_width; b++) begin
                if (pstrb[b]) begin
                    mem[array_index][b*8 +: 8] <= pwdata[b*8 +: 8];
                end
            end
        end
    end

endmodule

// ==== src/apb_delay_subsystem.sv ====
`timescale 1ns/1ps

module apb_delay_subsystem (
    input  logic                           clock,
    input  logic                           reset,
    input  logic [apb_pkg::addr_width-1:0] up_paddr,
    input  logic                           up_psel,
    input  logic                           up_penable,
    input  logic [apb_pkg::prot_width-1:0] up_pprot,
    input  logic                           up_pwrite,
    input  logic [apb_pkg::data_width-1:0] up_pwdata,
    input  logic [apb_pkg::strb_width-1:0] up_pstrb,
    output logic                           up_pready,
    output logic [apb_pkg::data_width-1:0] up_prdata,
    output logic                           up_pslverr
);

    logic                           cfg_psel;
    logic                           cfg_penable;
    logic [apb_pkg::addr_width-1:0] cfg_paddr;
    logic                           cfg_pwrite;
    logic [apb_pkg::data_width-1:0] cfg_pwdata;
    logic [apb_pkg::strb_width-1:0] cfg_pstrb;
    logic                           cfg_pready;
    logic [apb_pkg::data_width-1:0] cfg_prdata;
    logic                           cfg_pslverr;

    logic                           dly_psel;
    logic                           dly_penable;
    logic [apb_pkg::addr_width-1:0] dly_paddr;
    logic [apb_pkg::prot_width-1:0] dly_pprot;
    logic                           dly_pwrite;
    logic [apb_pkg::data_width-1:0] dly_pwdata;
    logic [apb_pkg::strb_width-1:0] dly_pstrb;
    logic                           dly_pready;
    logic [apb_pkg::data_width-1:0] dly_prdata;
    logic                           dly_pslverr;

    logic                           mem_psel;
    logic                           mem_penable;
    logic [apb_pkg::addr_width-1:0] mem_paddr;
    logic                           mem_pwrite;
    logic [apb_pkg::data_width-1:0] mem_pwdata;
    logic [apb_pkg::strb_width-1:0] mem_pstrb;
    logic                           mem_pready;
    logic [apb_pkg::data_width-1:0] mem_prdata;
    logic                           mem_pslverr;

    logic                           delay_enable;
    logic [apb_pkg::data_width-1:0] delay_ratio;
    logic                           access_done;

    apb_region_decoder apb_region_decoder_i (
        .up_paddr(up_paddr), .up_psel(up_psel), .up_penable(up_penable),
        .up_pprot(up_pprot), .up_pwrite(up_pwrite), .up_pwdata(up_pwdata),
        .up_pstrb(up_pstrb), .up_pready(up_pready), .up_prdata(up_prdata),
        .up_pslverr(up_pslverr),
        .cfg_psel(cfg_psel), .cfg_penable(cfg_penable), .cfg_paddr(cfg_paddr),
        .cfg_pwrite(cfg_pwrite), .cfg_pwdata(cfg_pwdata), .cfg_pstrb(cfg_pstrb),
        .cfg_pready(cfg_pready), .cfg_prdata(cfg_prdata), .cfg_pslverr(cfg_pslverr),
        .dly_psel(dly_psel), .dly_penable(dly_penable), .dly_paddr(dly_paddr),
        .dly_pprot(dly_pprot), .dly_pwrite(dly_pwrite), .dly_pwdata(dly_pwdata),
        .dly_pstrb(dly_pstrb), .dly_pready(dly_pready), .dly_prdata(dly_prdata),
        .dly_pslverr(dly_pslverr)
    );

    delay_config_regs delay_config_regs_i (
        .clock(clock), .reset(reset), .psel(cfg_psel), .penable(cfg_penable),
        .paddr(cfg_paddr), .pwrite(cfg_pwrite), .pwdata(cfg_pwdata), .pstrb(cfg_pstrb),
        .access_done(access_done), .pready(cfg_pready), .prdata(cfg_prdata),
        .pslverr(cfg_pslverr), .delay_enable(delay_enable), .delay_ratio(delay_ratio)
    );

    // pprot ends at the delayer since the memory has no protection input.
    apb_delayer apb_delayer_i (
        .clock(clock), .reset(reset), .delay_enable(delay_enable),
        .delay_ratio(delay_ratio),
        .in_paddr(dly_paddr), .in_psel(dly_psel), .in_penable(dly_penable),
        .in_pprot(dly_pprot), .in_pwrite(dly_pwrite), .in_pwdata(dly_pwdata),
        .in_pstrb(dly_pstrb), .in_pready(dly_pready), .in_prdata(dly_prdata),
        .in_pslverr(dly_pslverr),
        .out_paddr(mem_paddr), .out_psel(mem_psel), .out_penable(mem_penable),
        .out_pprot(), .out_pwrite(mem_pwrite), .out_pwdata(mem_pwdata),
        .out_pstrb(mem_pstrb), .out_pready(mem_pready), .out_prdata(mem_prdata),
        .out_pslverr(mem_pslverr), .access_done(access_done)
    );

    apb_wait_memory apb_wait_memory_i (
        .clock(clock), .reset(reset), .psel(mem_psel), .penable(mem_penable),
        .paddr(mem_paddr), .pwrite(mem_pwrite), .pwdata(mem_pwdata), .pstrb(mem_pstrb),
        .pready(mem_pready), .prdata(mem_prdata), .pslverr(mem_pslverr)
    );

endmodule

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // reset drops just after the sixteenth rising edge.
    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clock);
        #1 reset = 1'b0;
    end

endmodule

// ==== dv/apb_delay_checker.sv ====
`timescale 1ns/1ps

module apb_delay_checker (
    input  logic                           clock,
    input  logic                           reset,
    input  logic [apb_pkg::addr_width-1:0] up_paddr,
    input  logic                           up_psel,
    input  logic                           up_penable,
    input  logic                           up_pwrite,
    input  logic [apb_pkg::data_width-1:0] up_pwdata,
    input  logic [apb_pkg::strb_width-1:0] up_pstrb,
    input  logic                           up_pready,
    input  logic [apb_pkg::data_width-1:0] up_prdata,
    input  logic                           up_pslverr,
    output int                             check_count,
    output int                             error_count
);

    logic [apb_pkg::data_width-1:0] shadow [apb_pkg::mem_words];
    logic                           model_enable;
    logic [apb_pkg::data_width-1:0] model_ratio;
    logic [apb_pkg::data_width-1:0] model_count;

    logic                           busy;
    int                             cycle;
    int                             setup_cycle;
    logic [apb_pkg::addr_width-1:0] req_addr;
    logic                           req_write;
    logic [apb_pkg::data_width-1:0] req_wdata;
    logic [apb_pkg::strb_width-1:0] req_strb;

    function automatic logic [apb_pkg::data_width-1:0] merge_bytes(
        input logic [apb_pkg::data_width-1:0] old_word,
        input logic [apb_pkg::data_width-1:0] new_word,
        input logic [apb_pkg::strb_width-1:0] strb
    );
        logic [apb_pkg::data_width-1:0] result;
        result = old_word;
        for (int b = 0; b < apb_pkg::strb_width; b++) begin
            if (strb[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    // expected cycle of pready, read data and error for one transfer.
    function automatic void predict_response(
        input  logic [apb_pkg::addr_width-1:0] addr,
        input  logic                           write,
        output int                             latency,
        output logic [apb_pkg::data_width-1:0] rdata,
        output logic                           slverr
    );
        logic [apb_pkg::region_bit-3:0] index;
        logic [63:0]                    scaled;
        index = addr[apb_pkg::region_bit-1:2];
        scaled = 64'(apb_pkg::mem_wait_cycles) * {32'd0, model_ratio};
        latency = 1;
        rdata = '0;
        slverr = 1'b0;
        if (|(addr & apb_pkg::region_high_mask)) begin
            slverr = 1'b1;
        end else if (addr[apb_pkg::region_bit]) begin
            if (model_enable) begin
                latency = apb_pkg::mem_wait_cycles + 3
                        + int'(scaled >> delay_pkg::ratio_frac_bits);
            end else begin
                latency = apb_pkg::mem_wait_cycles + 1;
            end
            if (int'(index) >= apb_pkg::mem_words) begin
                slverr = 1'b1;
            end else if (!write) begin
                rdata = shadow[index[7:0]];
            end
        end else begin
            case (addr[delay_pkg::reg_offset_width-1:0])
                delay_pkg::reg_ctrl_offset: rdata = {31'd0, model_enable};
                delay_pkg::reg_ratio_offset: rdata = model_ratio;
                delay_pkg::reg_count_offset: begin
                    rdata = model_count;
                    slverr = write;
                end
                default: slverr = 1'b1;
            endcase
            if (write || slverr) begin
                rdata = '0;
            end
        end
    endfunction

    task automatic compare(input string name, input logic [31:0] expected, actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Fail at %0d ns: %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic update_model(input logic slverr);
        logic [apb_pkg::region_bit-3:0] index;
        index = req_addr[apb_pkg::region_bit-1:2];
        if (|(req_addr & apb_pkg::region_high_mask)) begin
            return;
        end
        if (req_addr[apb_pkg::region_bit]) begin
            // every access through an enabled delayer is counted even when it fails.
            if (model_enable) begin
                model_count++;
            end
            if (req_write && !slverr) begin
                shadow[index[7:0]] = merge_bytes(shadow[index[7:0]], req_wdata, req_strb);
            end
        end else if (req_write && !slverr) begin
            if (req_addr[delay_pkg::reg_offset_width-1:0] == delay_pkg::reg_ctrl_offset
                    && req_strb[0]) begin
                model_enable = req_wdata[0];
            end
            if (req_addr[delay_pkg::reg_offset_width-1:0] == delay_pkg::reg_ratio_offset) begin
                model_ratio = merge_bytes(model_ratio, req_wdata, req_strb);
            end
        end
    endtask

    always @(posedge clock) begin
        int                             exp_latency;
        logic [apb_pkg::data_width-1:0] exp_rdata;
        logic                           exp_slverr;
        if (reset) begin
            model_enable = 1'b0;
            model_ratio = delay_pkg::ratio_reset;
            model_count = '0;
            busy = 1'b0;
            cycle = 0;
            check_count = 0;
            error_count = 0;
        end else begin
            cycle++;
            if (!busy && up_psel && !up_penable) begin
                busy = 1'b1;
                setup_cycle = cycle;
                req_addr = up_paddr;
                req_write = up_pwrite;
                req_wdata = up_pwdata;
                req_strb = up_pstrb;
            end else if (busy && up_psel && up_penable && up_pready) begin
                predict_response(req_addr, req_write, exp_latency, exp_rdata, exp_slverr);
                compare("up_pready cycle", exp_latency, cycle - setup_cycle);
                compare("up_prdata", exp_rdata, up_prdata);
                compare("up_pslverr", {31'd0, exp_slverr}, {31'd0, up_pslverr});
                update_model(exp_slverr);
                busy = 1'b0;
            end
        end
    end

endmodule

// ==== dv/apb_delay_tb.sv ====
`timescale 1ns/1ps

module apb_delay_tb;

    localparam int ready_timeout = 100;
    localparam int reset_timeout = 40;
    localparam logic [31:0] ctrl_addr = 32'(delay_pkg::reg_ctrl_offset);
    localparam logic [31:0] ratio_addr = 32'(delay_pkg::reg_ratio_offset);
    localparam logic [31:0] count_addr = 32'(delay_pkg::reg_count_offset);

    logic                           clock;
    logic                           reset;
    logic [apb_pkg::addr_width-1:0] up_paddr;
    logic                           up_psel;
    logic                           up_penable;
    logic [apb_pkg::prot_width-1:0] up_pprot;
    logic                           up_pwrite;
    logic [apb_pkg::data_width-1:0] up_pwdata;
    logic [apb_pkg::strb_width-1:0] up_pstrb;
    logic                           up_pready;
    logic [apb_pkg::data_width-1:0] up_prdata;
    logic                           up_pslverr;

    int          check_count;
    int          error_count;
    int          errors_before;
    int          tests_done;
    logic [31:0] rng_state;

    tb_clock_gen clock_gen_i (
        .clock(clock),
        .reset(reset)
    );

    apb_delay_subsystem apb_delay_subsystem_i (
        .clock(clock), .reset(reset), .up_paddr(up_paddr), .up_psel(up_psel),
        .up_penable(up_penable), .up_pprot(up_pprot), .up_pwrite(up_pwrite),
        .up_pwdata(up_pwdata), .up_pstrb(up_pstrb), .up_pready(up_pready),
        .up_prdata(up_prdata), .up_pslverr(up_pslverr)
    );

    apb_delay_checker checker_i (
        .clock(clock), .reset(reset), .up_paddr(up_paddr), .up_psel(up_psel),
        .up_penable(up_penable), .up_pwrite(up_pwrite), .up_pwdata(up_pwdata),
        .up_pstrb(up_pstrb), .up_pready(up_pready), .up_prdata(up_prdata),
        .up_pslverr(up_pslverr), .check_count(check_count), .error_count(error_count)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] value);
        logic [31:0] x;
        x = value;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] mem_addr(input logic [9:0] index);
        return (32'd1 << apb_pkg::region_bit) | {20'd0, index, 2'b00};
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $finish;
    endtask

    // called 1 ns after a rising edge, returns 1 ns after the edge that saw pready.
    task automatic apb_transfer(
        input logic [31:0] addr,
        input logic        write,
        input logic [31:0] wdata,
        input logic [3:0]  strb
    );
        int waited;
        up_paddr = addr;
        up_pwrite = write;
        up_pwdata = wdata;
        up_pstrb = strb;
        up_psel = 1'b1;
        up_penable = 1'b0;
        @(posedge clock);
        #1 up_penable = 1'b1;
        waited = 0;
        @(posedge clock);
        while (!up_pready && waited < ready_timeout) begin
            @(posedge clock);
            waited++;
        end
        if (!up_pready) begin
            abort_run($sformatf("timeout: no pready for address %h", addr));
        end
        #1;
        up_psel = 1'b0;
        up_penable = 1'b0;
    endtask

    task automatic random_pair();
        logic [31:0] r;
        logic [31:0] data;
        rng_state = xorshift(rng_state);
        r = rng_state;
        rng_state = xorshift(rng_state);
        data = rng_state;
        apb_transfer(mem_addr({2'b00, r[7:0]}), 1'b1, data, r[11:8]);
        apb_transfer(mem_addr({2'b00, r[19:12]}), 1'b0, '0, '0);
        apb_transfer(mem_addr({2'b00, r[7:0]}), 1'b0, '0, '0);
    endtask

    task automatic run_ratio(input logic [31:0] ratio);
        apb_transfer(ratio_addr, 1'b1, ratio, 4'hf);
        random_pair();
        random_pair();
    endtask

    task automatic error_accesses();
        apb_transfer(mem_addr(10'd256), 1'b1, 32'hdead_beef, 4'hf);
        apb_transfer(mem_addr(10'd300), 1'b1, 32'h0bad_f00d, 4'hf);
        apb_transfer(mem_addr(10'd300), 1'b0, '0, '0);
        apb_transfer(mem_addr(10'd0), 1'b0, '0, '0);
        apb_transfer(mem_addr(10'd44), 1'b0, '0, '0);
    endtask

    task automatic end_test(input string name);
        @(posedge clock);
        #1;
        tests_done++;
        if (error_count == errors_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, error_count - errors_before);
        end
        errors_before = error_count;
    endtask

    initial begin
        int waited;
        up_paddr = '0;
        up_psel = 1'b0;
        up_penable = 1'b0;
        up_pprot = '0;
        up_pwrite = 1'b0;
        up_pwdata = '0;
        up_pstrb = '0;
        rng_state = 32'd18;
        errors_before = 0;
        tests_done = 0;

        waited = 0;
        @(posedge clock);
        while (reset && waited < reset_timeout) begin
            @(posedge clock);
            waited++;
        end
        if (reset) begin
            abort_run("timeout: reset was never released");
        end
        #1;

        apb_transfer(ctrl_addr, 1'b0, '0, '0);
        apb_transfer(ratio_addr, 1'b0, '0, '0);
        apb_transfer(count_addr, 1'b0, '0, '0);
        apb_transfer(ratio_addr, 1'b1, 32'haabb_ccdd, 4'b0101);
        apb_transfer(ratio_addr, 1'b0, '0, '0);
        apb_transfer(ctrl_addr, 1'b1, 32'h1, 4'b0000);
        apb_transfer(ctrl_addr, 1'b0, '0, '0);
        apb_transfer(count_addr, 1'b1, 32'h5, 4'hf);
        apb_transfer(32'h0000_000c, 1'b0, '0, '0);
        apb_transfer(ratio_addr, 1'b1, delay_pkg::ratio_reset, 4'hf);
        end_test("registers");

        // every word gets a known value before random traffic starts.
        for (int i = 0; i < apb_pkg::mem_words; i++) begin
            apb_transfer(mem_addr(10'(i)), 1'b1, 32'(i + 1) * 32'h9e37_79b9, 4'hf);
        end
        for (int i = 0; i < 40; i++) begin
            random_pair();
        end
        end_test("pass-through");

        apb_transfer(ctrl_addr, 1'b1, 32'h1, 4'h1);
        run_ratio(32'h0000_0000);
        run_ratio(32'h0000_0400);
        run_ratio(32'h0000_0a00);
        run_ratio(32'h0000_1f00);
        apb_transfer(ratio_addr, 1'b1, delay_pkg::ratio_reset, 4'hf);
        end_test("delayed accesses");

        apb_transfer(count_addr, 1'b0, '0, '0);
        for (int i = 0; i < 5; i++) begin
            random_pair();
        end
        apb_transfer(count_addr, 1'b0, '0, '0);
        apb_transfer(ctrl_addr, 1'b1, 32'h0, 4'h1);
        random_pair();
        apb_transfer(count_addr, 1'b0, '0, '0);
        end_test("access counter");

        apb_transfer(ctrl_addr, 1'b1, 32'h1, 4'h1);
        error_accesses();
        apb_transfer(ctrl_addr, 1'b1, 32'h0, 4'h1);
        error_accesses();
        apb_transfer(32'h0000_2000, 1'b0, '0, '0);
        apb_transfer(32'h8000_1000, 1'b1, 32'h1234_5678, 4'hf);
        end_test("errors");

        $display("%0d tests, %0d checks, %0d errors", tests_done, check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
src/apb_pkg.sv
src/delay_pkg.sv
src/apb_region_decoder.sv
src/delay_config_regs.sv
src/apb_delayer.sv
src/apb_wait_memory.sv
src/apb_delay_subsystem.sv
dv/tb_clock_gen.sv
dv/apb_delay_checker.sv
dv/apb_delay_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --top-module apb_delay_tb -f project.f -o apb_delay_sim
	out="$$(./obj_dir/apb_delay_sim)"; echo "$$out"; echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
